//--- rtl/trellis_defs.svh
`ifndef TRELLIS_DEFS_SVH
`define TRELLIS_DEFS_SVH

// sample and metric sizes
`define SAMPLE_BITS   10
`define ADD_BITS      8
`define METRIC_BITS   12

// trellis shape and survivor storage
`define NUM_STATES    4
`define TB_DEPTH      8
`define MEM_DEPTH     32
`define MEM_ADDR_BITS 5

`define NORM_OFFSET   512  // subtracted from every metric when one nears overflow

`endif

//--- rtl/trellisPkg.sv
`include "trellis_defs.svh"

package trellisPkg;

   // accumulated path metric, higher is a better match
   typedef logic signed [`METRIC_BITS-1:0] metricT;

   typedef struct packed {
      logic [`SAMPLE_BITS-1:0] re;
      logic [`SAMPLE_BITS-1:0] im;
   } sampleT;

   // branch samples into one state from its even and odd predecessor
   typedef struct packed {
      sampleT from0;
      sampleT from1;
   } branchPairT;

   typedef branchPairT [`NUM_STATES-1:0] branchSetT;  // all branches of one symbol

   typedef logic [1:0] stateT;

   // one bit per state, high when the odd predecessor survived
   typedef logic [`NUM_STATES-1:0] decisionT;

endpackage

//--- rtl/memBusPkg.sv
`include "trellis_defs.svh"

package memBusPkg;

   // one access to the survivor memory
   typedef struct packed {
      logic                       req;
      logic                       write;
      logic [`MEM_ADDR_BITS-1:0]  addr;
      trellisPkg::decisionT       wdata;
   } memReqT;

   // rvalid is only raised for a granted read, one cycle after the grant
   typedef struct packed {
      trellisPkg::decisionT rdata;
      logic                 rvalid;
   } memRspT;

endpackage

//--- rtl/acsUnit.sv
`include "trellis_defs.svh"

module acsUnit #(
   parameter type payloadT = trellisPkg::sampleT
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        symEn,
   input  logic                        normalize,
   input  trellisPkg::metricT          metric0,
   input  trellisPkg::metricT          metric1,
   input  logic signed [`ADD_BITS-1:0] add0,
   input  logic signed [`ADD_BITS-1:0] add1,
   input  payloadT                     pay0,
   input  payloadT                     pay1,
   output trellisPkg::metricT          metricOut,
   output logic                        decision,
   output payloadT                     payOut,
   output logic                        nearOverflow
);

   localparam int EXT_BITS = `METRIC_BITS - `ADD_BITS;
   localparam trellisPkg::metricT NORM = `NORM_OFFSET;

   trellisPkg::metricT sum0;
   trellisPkg::metricT sum1;
   trellisPkg::metricT winSum;
   trellisPkg::metricT normSum;
   trellisPkg::metricT nextMetric;
   logic               oddWins;

   // addends are sign extended up to the metric width before the add
   assign sum0 = metric0 + {{EXT_BITS{add0[`ADD_BITS-1]}}, add0};
   assign sum1 = metric1 + {{EXT_BITS{add1[`ADD_BITS-1]}}, add1};

   // signed compare, a tie leaves the even predecessor in place
   assign oddWins = sum1 > sum0;
   assign winSum  = oddWins ? sum1 : sum0;

   assign normSum = winSum - NORM;

   always_comb begin
      nextMetric = winSum;
      if (normalize) begin
         // a path that drops below zero is clamped there
         nextMetric = normSum[`METRIC_BITS-1] ? '0 : normSum;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         metricOut    <= '0;
         decision     <= 1'b0;
         nearOverflow <= 1'b0;
      end else if (symEn) begin
         metricOut    <= nextMetric;
         decision     <= oddWins;
         // flag follows the top two bits of the stored metric
         nearOverflow <= nextMetric[`METRIC_BITS-1 -: 2] == 2'b01;
      end
   end

   always_ff @(posedge clk) begin
      if (symEn) begin
         payOut <= oddWins ? pay1 : pay0;  // sample that came in on the surviving branch
      end
   end

endmodule

//--- rtl/acsBank.sv
`include "trellis_defs.svh"

module acsBank (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,
   input  trellisPkg::branchSetT     branches,
   output trellisPkg::decisionT      decisions,
   output logic                      decisionValid,
   output memBusPkg::memReqT         writeReq,
   output logic                      tbStart,
   output trellisPkg::stateT         bestState,
   output logic [`MEM_ADDR_BITS-1:0] tbAddr,
   output trellisPkg::metricT        bestMetric,
   output trellisPkg::sampleT        bestSample,
   output logic                      normalizing
);

   localparam int CNT_BITS = $clog2(`TB_DEPTH + 1);
   localparam logic [CNT_BITS-1:0] STORED_FULL = `TB_DEPTH;

   trellisPkg::metricT        metrics [`NUM_STATES];
   trellisPkg::sampleT        pays [`NUM_STATES];
   logic [`NUM_STATES-1:0]    overflowFlags;
   logic [`MEM_ADDR_BITS-1:0] wrPtr;
   logic [CNT_BITS-1:0]       storedCnt;
   trellisPkg::stateT         bestIdx;

   // next state is {input bit, old upper bit}, so state s is entered
   // from states 2s mod 4 and 2s mod 4 + 1
   for (genvar s = 0; s < `NUM_STATES; s++) begin : gState
      localparam int P0 = (2 * s) % `NUM_STATES;

      acsUnit #(.payloadT(trellisPkg::sampleT)) uAcs (
         .clk          (clk),
         .reset        (reset),
         .symEn        (symEn),
         .normalize    (normalizing),
         .metric0      (metrics[P0]),
         .metric1      (metrics[P0 + 1]),
         .add0         (branches[s].from0.re[`SAMPLE_BITS-1 -: `ADD_BITS]),
         .add1         (branches[s].from1.re[`SAMPLE_BITS-1 -: `ADD_BITS]),
         .pay0         (branches[s].from0),
         .pay1         (branches[s].from1),
         .metricOut    (metrics[s]),
         .decision     (decisions[s]),
         .payOut       (pays[s]),
         .nearOverflow (overflowFlags[s])
      );
   end

   assign normalizing = |overflowFlags;  // one flag shared by every unit

   assign writeReq = '{req: decisionValid, write: decisionValid, addr: wrPtr, wdata: decisions};

   // best state search, lowest index wins a tie
   always_comb begin
      bestIdx = '0;
      for (int i = 1; i < `NUM_STATES; i++) begin
         if (metrics[i] > metrics[bestIdx]) begin
            bestIdx = trellisPkg::stateT'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         decisionValid <= 1'b0;
         wrPtr         <= '0;
         storedCnt     <= '0;
         tbStart       <= 1'b0;
         bestState     <= '0;
         tbAddr        <= '0;
         bestMetric    <= '0;
         bestSample    <= '0;
      end else begin
         decisionValid <= symEn;
         tbStart       <= 1'b0;
         if (decisionValid) begin
            wrPtr <= wrPtr + 1'b1;  // MEM_DEPTH is a power of two so this wraps
            if (storedCnt != STORED_FULL) begin
               storedCnt <= storedCnt + 1'b1;
            end
            // the word written now counts toward the traceback depth
            tbStart    <= storedCnt >= STORED_FULL - 1'b1;
            bestState  <= bestIdx;
            tbAddr     <= wrPtr;
            bestMetric <= metrics[bestIdx];
            bestSample <= pays[bestIdx];
         end
      end
   end

endmodule

//--- rtl/survivorArbiter.sv
module survivorArbiter (
   input  logic              clk,
   input  logic              reset,
   input  memBusPkg::memReqT writeReq,
   input  memBusPkg::memReqT readReq,
   output memBusPkg::memReqT memReq,
   output logic              readGrant,
   output logic              readDone
);

   // the write comes once per symbol and can not wait, the reader holds its request
   assign readGrant = readReq.req && !writeReq.req;

   always_comb begin
      memReq = '0;
      if (writeReq.req) begin
         memReq = writeReq;
      end else if (readReq.req) begin
         memReq       = readReq;
         memReq.write = 1'b0;  // a read stays a read whatever the requester drove
      end
   end

   // remembers a granted read so only reads produce a response
   always_ff @(posedge clk) begin
      if (reset) begin
         readDone <= 1'b0;
      end else begin
         readDone <= readGrant;
      end
   end

endmodule

//--- rtl/survivorMem.sv
`include "trellis_defs.svh"

module survivorMem (
   input  logic              clk,
   input  memBusPkg::memReqT memReq,
   input  logic              readDone,
   output memBusPkg::memRspT memRsp
);

   trellisPkg::decisionT words [`MEM_DEPTH];
   trellisPkg::decisionT rdata;

   // single port, one access per cycle
   always_ff @(posedge clk) begin
      if (memReq.req) begin
         if (memReq.write) begin
            words[memReq.addr] <= memReq.wdata;
         end else begin
            rdata <= words[memReq.addr];
         end
      end
   end

   assign memRsp.rdata  = rdata;
   assign memRsp.rvalid = readDone;  // qualified by the arbiter

endmodule

//--- rtl/tracebackUnit.sv
`include "trellis_defs.svh"

module tracebackUnit (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      tbStart,
   input  trellisPkg::stateT         bestState,
   input  logic [`MEM_ADDR_BITS-1:0] tbAddr,
   input  logic                      readGrant,
   input  memBusPkg::memRspT         memRsp,
   output memBusPkg::memReqT         readReq,
   output logic                      decodedBit,
   output logic                      bitValid
);

   localparam int CNT_BITS = $clog2(`TB_DEPTH + 1);
   localparam logic [CNT_BITS-1:0] STEPS = `TB_DEPTH;
   localparam logic [CNT_BITS-1:0] LAST_STEP = 1;

   logic [CNT_BITS-1:0]       readsLeft;
   logic [CNT_BITS-1:0]       rspLeft;
   logic [`MEM_ADDR_BITS-1:0] rdAddr;
   trellisPkg::stateT         tbState;
   logic                      decisionBit;

   assign decisionBit = memRsp.rdata[tbState];

   // request stays up, unchanged, until the arbiter grants it
   assign readReq = '{req: readsLeft != '0, write: 1'b0, addr: rdAddr, wdata: '0};

   // reads are issued ahead of the responses since the address
   // sequence does not depend on the data
   always_ff @(posedge clk) begin
      if (reset) begin
         readsLeft <= '0;
         rspLeft   <= '0;
         bitValid  <= 1'b0;
      end else begin
         bitValid <= 1'b0;
         if (tbStart) begin
            readsLeft <= STEPS;
            rspLeft   <= STEPS;
         end else begin
            if (readGrant) begin
               readsLeft <= readsLeft - 1'b1;
            end
            if (memRsp.rvalid && rspLeft != '0) begin
               rspLeft  <= rspLeft - 1'b1;
               bitValid <= rspLeft == LAST_STEP;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tbStart) begin
         tbState <= bestState;
         rdAddr  <= tbAddr;  // newest word first
      end else begin
         if (readGrant) begin
            rdAddr <= rdAddr - 1'b1;  // wraps around the survivor memory
         end
         if (memRsp.rvalid) begin
            // the predecessor keeps our low bit on top and takes the decision below,
            // so each step shifts the old upper bit out
            tbState <= {tbState[0], decisionBit};
            if (rspLeft == LAST_STEP) begin
               decodedBit <= tbState[1];  // input bit of the oldest symbol still on the path
            end
         end
      end
   end

endmodule

//--- rtl/trellisDecoder.sv
`include "trellis_defs.svh"

module trellisDecoder (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  symEn,
   input  trellisPkg::branchSetT branches,
   output logic                  decodedBit,
   output logic                  bitValid,
   output trellisPkg::metricT    bestMetric,
   output trellisPkg::sampleT    bestSample,
   output logic                  normalizing
);

   memBusPkg::memReqT         writeReq;
   memBusPkg::memReqT         readReq;
   memBusPkg::memReqT         memReq;
   memBusPkg::memRspT         memRsp;
   logic                      readGrant;
   logic                      readDone;
   logic                      tbStart;
   trellisPkg::stateT         bestState;
   logic [`MEM_ADDR_BITS-1:0] tbAddr;

   // metrics, decisions and the survivor writes
   acsBank uBank (
      .clk           (clk),
      .reset         (reset),
      .symEn         (symEn),
      .branches      (branches),
      .decisions     (),
      .decisionValid (),
      .writeReq      (writeReq),
      .tbStart       (tbStart),
      .bestState     (bestState),
      .tbAddr        (tbAddr),
      .bestMetric    (bestMetric),
      .bestSample    (bestSample),
      .normalizing   (normalizing)
   );

   survivorArbiter uArb (
      .clk       (clk),
      .reset     (reset),
      .writeReq  (writeReq),
      .readReq   (readReq),
      .memReq    (memReq),
      .readGrant (readGrant),
      .readDone  (readDone)
   );

   survivorMem uMem (
      .clk      (clk),
      .memReq   (memReq),
      .readDone (readDone),
      .memRsp   (memRsp)
   );

   tracebackUnit uTrace (
      .clk        (clk),
      .reset      (reset),
      .tbStart    (tbStart),
      .bestState  (bestState),
      .tbAddr     (tbAddr),
      .readGrant  (readGrant),
      .memRsp     (memRsp),
      .readReq    (readReq),
      .decodedBit (decodedBit),
      .bitValid   (bitValid)
   );

endmodule

//--- sim/trellisDecoder_asserts.sv
`include "trellis_defs.svh"

module trellisDecoder_asserts (
   input logic               clk,
   input logic               reset,
   input logic               symEn,
   input logic               bitValid,
   input trellisPkg::metricT bestMetric
);

   localparam logic [5:0] MIN_GAP = `TB_DEPTH + 4;
   localparam logic [3:0] FIRST_TB = `TB_DEPTH - 1;  // symbols stored before a traceback starts

   logic [5:0] gapCycles;  // cycles since the last symEn, saturating
   logic [3:0] symCount;
   logic       bitOwed;    // a traceback was started and its bit has not come yet

   always_ff @(posedge clk) begin
      if (reset) begin
         gapCycles <= '1;
         symCount  <= '0;
         bitOwed   <= 1'b0;
      end else begin
         if (symEn) begin
            gapCycles <= 6'd1;
         end else if (gapCycles != '1) begin
            gapCycles <= gapCycles + 6'd1;
         end
         if (symEn && symCount != FIRST_TB) begin
            symCount <= symCount + 4'd1;
         end
         if (bitValid) begin
            bitOwed <= 1'b0;
         end
         if (symEn && symCount == FIRST_TB) begin
            bitOwed <= 1'b1;
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset) bitValid |=> !bitValid)
      else $error("bitValid stayed high for two cycles");

   assert property (@(posedge clk) disable iff (reset) symEn |-> gapCycles >= MIN_GAP)
      else $error("symEn strobes closer than the traceback needs");

   // at the minimum spacing the bit shows up in the same cycle as the next symEn
   assert property (@(posedge clk) disable iff (reset) symEn |-> !bitOwed || bitValid)
      else $error("symEn arrived before the pending decoded bit");

   assert property (@(posedge clk) disable iff (reset) bitValid |-> bitOwed)
      else $error("decoded bit without a pending traceback");

   assert property (@(posedge clk) disable iff (reset) !bestMetric[`METRIC_BITS-1])
      else $error("bestMetric went negative");

endmodule

bind trellisDecoder trellisDecoder_asserts uChecks (
   .clk        (clk),
   .reset      (reset),
   .symEn      (symEn),
   .bitValid   (bitValid),
   .bestMetric (bestMetric)
);

//--- sim/trellisDecoderTb.sv
`include "trellis_defs.svh"

module trellisDecoderTb;

   localparam int NUM_SYMBOLS    = 300;
   localparam int TIMEOUT_CYCLES = NUM_SYMBOLS * 20 + 100;
   localparam int EXPECTED_BITS  = NUM_SYMBOLS - (`TB_DEPTH - 1);
   localparam int OVERFLOW_LEVEL = 1 << (`METRIC_BITS - 2);  // top two metric bits read 01 here

   logic                  clk;
   logic                  reset;
   logic                  symEn;
   trellisPkg::branchSetT branches;
   logic                  decodedBit;
   logic                  bitValid;
   trellisPkg::metricT    bestMetric;
   trellisPkg::sampleT    bestSample;
   logic                  normalizing;

   logic sentBits [$];  // input bits still waiting for their traceback
   logic expectedBit;
   int   decodedCount = 0;
   int   normCycles = 0;
   int   cycleCount = 0;

   trellisDecoder UUT (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .branches    (branches),
      .decodedBit  (decodedBit),
      .bitValid    (bitValid),
      .bestMetric  (bestMetric),
      .bestSample  (bestSample),
      .normalizing (normalizing)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic checkQuiet();
      assert (bitValid === 1'b0 && normalizing === 1'b0 && bestMetric === '0 &&
              bestSample === '0)
         else abortRun($sformatf("Error at %0t: outputs not cleared around reset", $time));
   endtask

   // every branch gets a weak sample except the one on the true transition
   task automatic makeBranches(input trellisPkg::stateT fromState,
                               input trellisPkg::stateT toState,
                               output trellisPkg::branchSetT set,
                               output trellisPkg::sampleT trueSample);
      int unsigned re;
      int unsigned im;
      logic        onPath;
      trellisPkg::sampleT smp;
      for (int st = 0; st < `NUM_STATES; st++) begin
         for (int side = 0; side < 2; side++) begin
            onPath = st == int'(toState) && side == int'(fromState[0]);
            re = onPath ? $urandom_range(511, 400) : $urandom_range(150, 0);
            im = $urandom_range(1023, 0);
            smp.re = re[`SAMPLE_BITS-1:0];
            smp.im = im[`SAMPLE_BITS-1:0];
            if (side == 0) begin
               set[st].from0 = smp;
            end else begin
               set[st].from1 = smp;
            end
            if (onPath) begin
               trueSample = smp;
            end
         end
      end
   endtask

   initial begin
      int unsigned           seed;
      trellisPkg::stateT     encState;
      trellisPkg::stateT     nextState;
      trellisPkg::sampleT    trueSample;
      trellisPkg::branchSetT symBranches;
      logic                  inBit;
      int                    modelMetric;
      logic                  modelNorm;
      int                    gap;

      seed = $urandom(32'h15faa389);
      reset = 1'b1;
      symEn = 1'b0;
      branches = '0;
      encState = '0;
      modelMetric = 0;
      modelNorm = 1'b0;

      repeat (8) begin
         @(negedge clk);
         checkQuiet();
      end
      reset = 1'b0;
      @(negedge clk);
      checkQuiet();

      for (int n = 0; n < NUM_SYMBOLS; n++) begin
         inBit = 1'($urandom_range(1, 0));
         nextState = {inBit, encState[1]};  // new bit on top, old upper bit shifts down
         makeBranches(encState, nextState, symBranches, trueSample);
         symEn = 1'b1;
         branches = symBranches;
         sentBits.push_back(inBit);

         // the true path always survives, so its metric is the best one
         modelMetric = modelMetric + int'(trueSample.re[`SAMPLE_BITS-1 -: `ADD_BITS]);
         if (modelNorm) begin
            modelMetric = modelMetric - `NORM_OFFSET;
         end
         modelNorm = modelMetric >= OVERFLOW_LEVEL;

         @(negedge clk);
         symEn = 1'b0;
         branches = '0;
         @(negedge clk);
         assert (bestSample === trueSample)
            else abortRun($sformatf("Error at %0t: bestSample %h, expected %h",
                                    $time, bestSample, trueSample));
         assert (bestMetric === trellisPkg::metricT'(modelMetric))
            else abortRun($sformatf("Error at %0t: bestMetric %0d, expected %0d",
                                    $time, bestMetric, modelMetric));
         assert (normalizing === modelNorm)
            else abortRun($sformatf("Error at %0t: normalizing %b, expected %b",
                                    $time, normalizing, modelNorm));
         encState = nextState;
         gap = $urandom_range(`TB_DEPTH + 8, `TB_DEPTH + 4);
         repeat (gap - 2) @(negedge clk);
      end

      while (decodedCount < EXPECTED_BITS) @(negedge clk);
      repeat (`TB_DEPTH + 8) @(negedge clk);  // room for a stray extra bit to show up

      if (decodedCount == EXPECTED_BITS && sentBits.size() == `TB_DEPTH - 1 &&
          normCycles > 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         abortRun($sformatf("Decoded %0d of %0d bits, normalization seen in %0d cycles",
                            decodedCount, EXPECTED_BITS, normCycles));
      end
   end

   // decoded bits come back oldest first
   always @(negedge clk) begin
      if (!reset) begin
         if (normalizing === 1'b1) begin
            normCycles++;
         end
         if (bitValid === 1'b1) begin
            assert (sentBits.size() > 0)
               else abortRun("bitValid was raised with no symbol left to decode");
            expectedBit = sentBits.pop_front();
            assert (decodedBit === expectedBit)
               else abortRun($sformatf("Error at %0t: decoded bit %b, expected %b",
                                       $time, decodedBit, expectedBit));
            decodedCount++;
         end
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         abortRun($sformatf("Timeout after %0d cycles with %0d of %0d bits decoded",
                            cycleCount, decodedCount, EXPECTED_BITS));
      end
   end

endmodule

//--- compile.f
+incdir+rtl
rtl/trellisPkg.sv
rtl/memBusPkg.sv
rtl/acsUnit.sv
rtl/acsBank.sv
rtl/survivorArbiter.sv
rtl/survivorMem.sv
rtl/tracebackUnit.sv
rtl/trellisDecoder.sv
sim/trellisDecoder_asserts.sv
sim/trellisDecoderTb.sv

//--- run.sh
#!/bin/bash
# builds the trellis decoder testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv -Wno-fatal \
   -f compile.f --top-module trellisDecoderTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VtrellisDecoderTb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
